// ==== source/bp_pkg.sv ====
package bp_pkg;

    // address and operand widths
    localparam int PC_WIDTH   = 32;
    localparam int DATA_WIDTH = 32;

    // first fetch address after reset
    localparam logic [PC_WIDTH-1:0] RESET_PC = 32'h1c000000;

    // pht indexed by pc[7:2]
    localparam int PHT_INDEX_BITS = 6;
    localparam int PHT_ENTRIES    = 1 << PHT_INDEX_BITS;

    // btb indexed by pc[6:2], tag is everything above
    localparam int BTB_INDEX_BITS = 5;
    localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
    localparam int BTB_TAG_BITS   = PC_WIDTH - BTB_INDEX_BITS - 2;

    // branch condition kinds from decode
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_op_e;

    // 2-bit counter, msb set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } pht_state_e;

endpackage

// ==== source/pht.sv ====
module pht import bp_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [PC_WIDTH-1:0] fetch_pc_i,
    input  logic [PC_WIDTH-1:0] res_pc_i,
    input  logic                we_i,
    input  pht_state_e          wstate_i,
    output pht_state_e          fetch_state_o,
    output pht_state_e          res_state_o
);

    pht_state_e                table_q [PHT_ENTRIES];
    logic [PHT_INDEX_BITS-1:0] fetch_idx;
    logic [PHT_INDEX_BITS-1:0] res_idx;

    // word aligned pcs, drop the low two bits
    assign fetch_idx = fetch_pc_i[PHT_INDEX_BITS+1:2];
    assign res_idx   = res_pc_i[PHT_INDEX_BITS+1:2];

    // async reads for fetch prediction
    assign fetch_state_o = table_q[fetch_idx];

    // and for the resolving branch in execute
    assign res_state_o = table_q[res_idx];

    // counters are predictor state, all start weakly not taken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                table_q[i] <= WEAK_NT;
            end
        end else if (we_i) begin
            // write lands on the edge, same-cycle reads see old value
            table_q[res_idx] <= wstate_i;
        end
    end

endmodule

// ==== source/btb.sv ====
module btb import bp_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [PC_WIDTH-1:0] lookup_pc_i,
    input  logic                we_i,
    input  logic [PC_WIDTH-1:0] wpc_i,
    input  logic [PC_WIDTH-1:0] wtarget_i,
    output logic                hit_o,
    output logic [PC_WIDTH-1:0] target_o
);

    logic [BTB_ENTRIES-1:0]    valid_q;
    logic [BTB_TAG_BITS-1:0]   tag_q    [BTB_ENTRIES];
    logic [PC_WIDTH-1:0]       target_q [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [BTB_TAG_BITS-1:0]   lookup_tag;
    logic [BTB_INDEX_BITS-1:0] w_idx;
    logic [BTB_TAG_BITS-1:0]   w_tag;

    // pc split: tag | index | 2'b00
    assign lookup_idx = lookup_pc_i[BTB_INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc_i[PC_WIDTH-1:BTB_INDEX_BITS+2];
    assign w_idx      = wpc_i[BTB_INDEX_BITS+1:2];
    assign w_tag      = wpc_i[PC_WIDTH-1:BTB_INDEX_BITS+2];

    // hit needs a live entry and a matching tag
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    // valid bits cleared at reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[w_idx] <= 1'b1;
        end
    end

    // tag and target storage, whole entry overwritten
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[w_idx]    <= w_tag;
            target_q[w_idx] <= wtarget_i;
        end
    end

endmodule

// ==== source/pc_gen.sv ====
module pc_gen import bp_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  logic [PC_WIDTH-1:0] redirect_pc_i,
    input  logic                pred_taken_i,
    input  logic [PC_WIDTH-1:0] pred_target_i,
    output logic [PC_WIDTH-1:0] pc_o,
    output logic [PC_WIDTH-1:0] next_pc_o
);

    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] seq_pc;

    // fall-through address
    assign seq_pc = pc_q + PC_WIDTH'(4);

    // btb target when predicted taken
    assign next_pc_o = pred_taken_i ? pred_target_i : seq_pc;
    assign pc_o      = pc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            // redirect beats stall
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= next_pc_o;
        end
        // stalled, hold
    end

endmodule

// ==== source/branch_unit.sv ====
module branch_unit import bp_pkg::*; (
    input  logic                  valid_i,
    input  logic [PC_WIDTH-1:0]   pc_i,
    input  branch_op_e            op_i,
    input  logic                  jmp_i,
    input  logic                  base_src_i,
    input  logic                  offs_src_i,
    input  logic [DATA_WIDTH-1:0] rdata1_i,
    input  logic [DATA_WIDTH-1:0] rdata2_i,
    input  logic [15:0]           imm16_i,
    input  logic [25:0]           imm26_i,
    input  logic                  pred_taken_i,
    input  logic [PC_WIDTH-1:0]   pred_pc_i,
    input  pht_state_e            pht_state_i,
    output logic                  flush_o,
    output logic [PC_WIDTH-1:0]   redirect_pc_o,
    output logic                  pht_we_o,
    output pht_state_e            pht_wstate_o,
    output logic                  btb_we_o,
    output logic [PC_WIDTH-1:0]   btb_target_o
);

    logic                is_branch;
    logic                lt_s;
    logic                lt_u;
    logic                cond;
    logic                taken;
    logic [PC_WIDTH-1:0] base_addr;
    logic [PC_WIDTH-1:0] offs_addr;
    logic [PC_WIDTH-1:0] target;
    logic [PC_WIDTH-1:0] seq_pc;
    logic                dir_miss;
    logic                tgt_miss;

    // only real branches or jumps resolve here
    assign is_branch = valid_i && (jmp_i || (op_i != BR_NONE));

    // both compare flavours shared by the cases below
    assign lt_s = $signed(rdata1_i) < $signed(rdata2_i);
    assign lt_u = rdata1_i < rdata2_i;

    always_comb begin
        case (op_i)
            BR_EQ:   cond = (rdata1_i == rdata2_i);
            BR_NE:   cond = (rdata1_i != rdata2_i);
            BR_LT:   cond = lt_s;
            // ge is just not less-than
            BR_GE:   cond = ~lt_s;
            BR_LTU:  cond = lt_u;
            BR_GEU:  cond = ~lt_u;
            default: cond = 1'b0;
        endcase
    end

    // unconditional jump overrides the compare
    assign taken = jmp_i || cond;

    // base is rs1 or the branch pc
    assign base_addr = base_src_i ? rdata1_i : pc_i;

    // word offsets, sign extended then shifted by two
    assign offs_addr = offs_src_i ?
                       {{(PC_WIDTH-28){imm26_i[25]}}, imm26_i, 2'b00} :
                       {{(PC_WIDTH-18){imm16_i[15]}}, imm16_i, 2'b00};

    assign target = base_addr + offs_addr;
    assign seq_pc = pc_i + PC_WIDTH'(4);

    // wrong direction, or right direction but wrong target
    assign dir_miss = (taken != pred_taken_i);
    assign tgt_miss = taken && (target != pred_pc_i);

    assign flush_o       = is_branch && (dir_miss || tgt_miss);
    assign redirect_pc_o = taken ? target : seq_pc;

    // counter trains on every resolved branch
    assign pht_we_o = is_branch;

    always_comb begin
        pht_wstate_o = pht_state_i;
        if (taken) begin
            // count up, stick at strong taken
            if (pht_state_i != STRONG_T) begin
                pht_wstate_o = pht_state_e'(pht_state_i + 2'd1);
            end
        end else begin
            // count down, stick at strong not taken
            if (pht_state_i != STRONG_NT) begin
                pht_wstate_o = pht_state_e'(pht_state_i - 2'd1);
            end
        end
    end

    // fill btb only when a taken branch was mispredicted
    assign btb_we_o     = is_branch && taken && flush_o;
    assign btb_target_o = target;

endmodule

// ==== source/branch_predictor_top.sv ====
module branch_predictor_top import bp_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  ex_valid_i,
    input  logic [PC_WIDTH-1:0]   ex_pc_i,
    input  branch_op_e            ex_op_i,
    input  logic                  ex_jmp_i,
    input  logic                  ex_base_src_i,
    input  logic                  ex_offs_src_i,
    input  logic [DATA_WIDTH-1:0] ex_rdata1_i,
    input  logic [DATA_WIDTH-1:0] ex_rdata2_i,
    input  logic [15:0]           ex_imm16_i,
    input  logic [25:0]           ex_imm26_i,
    input  logic                  ex_pred_taken_i,
    input  logic [PC_WIDTH-1:0]   ex_pred_pc_i,
    output logic [PC_WIDTH-1:0]   fetch_pc_o,
    output logic                  fetch_pred_taken_o,
    output logic [PC_WIDTH-1:0]   fetch_pred_pc_o,
    output logic                  flush_o,
    output logic [PC_WIDTH-1:0]   redirect_pc_o
);

    pht_state_e          fetch_state;
    pht_state_e          res_state;
    logic                pht_we;
    pht_state_e          pht_wstate;
    logic                btb_hit;
    logic [PC_WIDTH-1:0] btb_target;
    logic                btb_we;
    logic [PC_WIDTH-1:0] btb_wtarget;

    // taken needs a btb hit and a counter msb
    assign fetch_pred_taken_o = btb_hit && fetch_state[1];

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_o),
        .redirect_pc_i (redirect_pc_o),
        .pred_taken_i  (fetch_pred_taken_o),
        .pred_target_i (btb_target),
        .pc_o          (fetch_pc_o),
        .next_pc_o     (fetch_pred_pc_o)
    );

    // fetch read at current pc, resolve read and write at ex pc
    pht u_pht (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_pc_i    (fetch_pc_o),
        .res_pc_i      (ex_pc_i),
        .we_i          (pht_we),
        .wstate_i      (pht_wstate),
        .fetch_state_o (fetch_state),
        .res_state_o   (res_state)
    );

    btb u_btb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup_pc_i (fetch_pc_o),
        .we_i        (btb_we),
        .wpc_i       (ex_pc_i),
        .wtarget_i   (btb_wtarget),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    branch_unit u_branch_unit (
        .valid_i       (ex_valid_i),
        .pc_i          (ex_pc_i),
        .op_i          (ex_op_i),
        .jmp_i         (ex_jmp_i),
        .base_src_i    (ex_base_src_i),
        .offs_src_i    (ex_offs_src_i),
        .rdata1_i      (ex_rdata1_i),
        .rdata2_i      (ex_rdata2_i),
        .imm16_i       (ex_imm16_i),
        .imm26_i       (ex_imm26_i),
        .pred_taken_i  (ex_pred_taken_i),
        .pred_pc_i     (ex_pred_pc_i),
        .pht_state_i   (res_state),
        .flush_o       (flush_o),
        .redirect_pc_o (redirect_pc_o),
        .pht_we_o      (pht_we),
        .pht_wstate_o  (pht_wstate),
        .btb_we_o      (btb_we),
        .btb_target_o  (btb_wtarget)
    );

endmodule

// ==== tb/tb_checker.sv ====
module tb_checker import bp_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  ex_valid_i,
    input  logic [PC_WIDTH-1:0]   ex_pc_i,
    input  branch_op_e            ex_op_i,
    input  logic                  ex_jmp_i,
    input  logic                  ex_base_src_i,
    input  logic                  ex_offs_src_i,
    input  logic [DATA_WIDTH-1:0] ex_rdata1_i,
    input  logic [DATA_WIDTH-1:0] ex_rdata2_i,
    input  logic [15:0]           ex_imm16_i,
    input  logic [25:0]           ex_imm26_i,
    input  logic                  ex_pred_taken_i,
    input  logic [PC_WIDTH-1:0]   ex_pred_pc_i,
    input  logic [PC_WIDTH-1:0]   fetch_pc_i,
    input  logic                  fetch_pred_taken_i,
    input  logic [PC_WIDTH-1:0]   fetch_pred_pc_i,
    input  logic                  flush_i,
    input  logic [PC_WIDTH-1:0]   redirect_pc_i,
    output int                    check_count_o,
    output int                    err_count_o
);

    // shadow copies of the predictor tables
    logic [1:0]          sh_pht   [PHT_ENTRIES];
    logic                sh_valid [BTB_ENTRIES];
    logic [PC_WIDTH-1:0] sh_pc    [BTB_ENTRIES];
    logic [PC_WIDTH-1:0] sh_tgt   [BTB_ENTRIES];
    logic [PC_WIDTH-1:0] exp_pc;

    initial begin
        check_count_o = 0;
        err_count_o   = 0;
    end

    // result packs {is_branch, taken, flush, redirect}
    function automatic logic [PC_WIDTH+2:0] ref_resolve(
        input logic                  valid,
        input logic [PC_WIDTH-1:0]   pc,
        input branch_op_e            op,
        input logic                  jmp,
        input logic                  base_src,
        input logic                  offs_src,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b,
        input logic [15:0]           imm16,
        input logic [25:0]           imm26,
        input logic                  pred_taken,
        input logic [PC_WIDTH-1:0]   pred_pc
    );
        logic signed [PC_WIDTH-1:0] offs;
        logic [PC_WIDTH-1:0]        target;
        logic                       lt_s;
        logic                       cond;
        logic                       is_br;
        logic                       taken;
        logic                       flush;
        // signed less-than by flipping both sign bits
        lt_s = {~a[31], a[30:0]} < {~b[31], b[30:0]};
        case (op)
            BR_EQ:   cond = (a == b);
            BR_NE:   cond = (a != b);
            BR_LT:   cond = lt_s;
            BR_GE:   cond = !lt_s;
            BR_LTU:  cond = (a < b);
            BR_GEU:  cond = !(a < b);
            default: cond = 1'b0;
        endcase
        is_br = valid && (jmp || (op != BR_NONE));
        taken = jmp || cond;
        if (offs_src) begin
            offs = $signed(imm26);
        end else begin
            offs = $signed(imm16);
        end
        target = (base_src ? a : pc) + (offs <<< 2);
        flush  = is_br && ((taken != pred_taken) || (taken && (target != pred_pc)));
        return {is_br, taken, flush, taken ? target : pc + 32'd4};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count_o++;
        if (act !== exp) begin
            err_count_o++;
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // everything settled mid-cycle, check then step the model
    always @(negedge clk_i) begin : watch
        logic [PC_WIDTH+2:0]       res;
        logic [PHT_INDEX_BITS-1:0] pi;
        logic [BTB_INDEX_BITS-1:0] bi;
        logic                      exp_taken;
        logic [PC_WIDTH-1:0]       exp_next;
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                sh_pht[i] = WEAK_NT;
            end
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                sh_valid[i] = 1'b0;
                sh_pc[i]    = '0;
                sh_tgt[i]   = '0;
            end
            exp_pc = RESET_PC;
        end else begin
            res = ref_resolve(ex_valid_i, ex_pc_i, ex_op_i, ex_jmp_i, ex_base_src_i,
                              ex_offs_src_i, ex_rdata1_i, ex_rdata2_i, ex_imm16_i,
                              ex_imm26_i, ex_pred_taken_i, ex_pred_pc_i);
            // fetch prediction sees the tables before this cycle's writes
            pi = exp_pc[7:2];
            bi = exp_pc[6:2];
            exp_taken = sh_valid[bi] && (sh_pc[bi][31:7] == exp_pc[31:7]) && sh_pht[pi][1];
            exp_next  = exp_taken ? sh_tgt[bi] : exp_pc + 32'd4;
            check_value("fetch_pc_o", exp_pc, fetch_pc_i);
            check_value("fetch_pred_taken_o", exp_taken, fetch_pred_taken_i);
            check_value("fetch_pred_pc_o", exp_next, fetch_pred_pc_i);
            check_value("flush_o", res[32], flush_i);
            check_value("redirect_pc_o", res[31:0], redirect_pc_i);
            // saturating counter step
            pi = ex_pc_i[7:2];
            if (res[34] && res[33] && (sh_pht[pi] != STRONG_T)) begin
                sh_pht[pi] = sh_pht[pi] + 2'd1;
            end else if (res[34] && !res[33] && (sh_pht[pi] != STRONG_NT)) begin
                sh_pht[pi] = sh_pht[pi] - 2'd1;
            end
            // btb fill on a taken mispredict
            if (res[34] && res[33] && res[32]) begin
                bi           = ex_pc_i[6:2];
                sh_valid[bi] = 1'b1;
                sh_pc[bi]    = ex_pc_i;
                sh_tgt[bi]   = res[31:0];
            end
            // redirect, then hold, then predicted pc
            if (res[32]) begin
                exp_pc = res[31:0];
            end else if (!stall_i) begin
                exp_pc = exp_next;
            end
        end
    end

endmodule

// ==== tb/tb_top.sv ====
module tb_top import bp_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int COND_CYCLES  = 280;
    localparam int TGT_CYCLES   = 160;
    localparam int TRAIN_CYCLES = 16;
    localparam int SEQ_CYCLES   = 240;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + COND_CYCLES + TGT_CYCLES
                                  + 2 * TRAIN_CYCLES + SEQ_CYCLES + 100;
    // branch to itself so fetch loops here once trained
    localparam logic [PC_WIDTH-1:0] TRAIN_PC = 32'h1c000040;

    logic                  clk_i           = 1'b0;
    logic                  rst_n_i         = 1'b0;
    logic                  stall_i         = 1'b0;
    logic                  ex_valid_i      = 1'b0;
    logic [PC_WIDTH-1:0]   ex_pc_i         = RESET_PC;
    branch_op_e            ex_op_i         = BR_NONE;
    logic                  ex_jmp_i        = 1'b0;
    logic                  ex_base_src_i   = 1'b0;
    logic                  ex_offs_src_i   = 1'b0;
    logic [DATA_WIDTH-1:0] ex_rdata1_i     = '0;
    logic [DATA_WIDTH-1:0] ex_rdata2_i     = '0;
    logic [15:0]           ex_imm16_i      = '0;
    logic [25:0]           ex_imm26_i      = '0;
    logic                  ex_pred_taken_i = 1'b0;
    logic [PC_WIDTH-1:0]   ex_pred_pc_i    = '0;
    logic [PC_WIDTH-1:0]   fetch_pc_o;
    logic                  fetch_pred_taken_o;
    logic [PC_WIDTH-1:0]   fetch_pred_pc_o;
    logic                  flush_o;
    logic [PC_WIDTH-1:0]   redirect_pc_o;
    int                    check_count;
    int                    err_count;
    int                    cycles = 0;
    logic [31:0]           lfsr   = 32'd80;
    logic [31:0]           pick;

    branch_predictor_top uut (.*);

    tb_checker u_checker (
        .fetch_pc_i         (fetch_pc_o),
        .fetch_pred_taken_i (fetch_pred_taken_o),
        .fetch_pred_pc_i    (fetch_pred_pc_o),
        .flush_i            (flush_o),
        .redirect_pc_i      (redirect_pc_o),
        .check_count_o      (check_count),
        .err_count_o        (err_count),
        .*
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // random word or one of the sign-boundary values
    task automatic pick_operand(output logic [31:0] val);
        logic [31:0] sel;
        take_bits(2, sel);
        case (sel[1:0])
            2'd0:    take_bits(32, val);
            2'd1:    val = 32'h7fffffff;
            2'd2:    val = 32'h80000000;
            default: val = 32'hffffffff;
        endcase
    endtask

    task automatic drive_random(input logic valid, input logic jmp, input branch_op_e op);
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        pc;
        logic [31:0]        f;
        logic [31:0]        i16;
        logic [31:0]        i26;
        logic [31:0]        r;
        logic signed [31:0] offs;
        logic [31:0]        tgt;
        pick_operand(a);
        pick_operand(b);
        take_bits(30, pc);
        take_bits(6, f);
        take_bits(16, i16);
        take_bits(26, i26);
        take_bits(30, r);
        pc = {pc[29:0], 2'b00};
        // target if taken lets some guesses be exactly right
        if (f[1]) begin
            offs = $signed(i26[25:0]);
        end else begin
            offs = $signed(i16[15:0]);
        end
        tgt = (f[0] ? a : pc) + (offs <<< 2);
        @(posedge clk_i);
        ex_valid_i      <= valid;
        ex_jmp_i        <= jmp;
        ex_op_i         <= op;
        ex_pc_i         <= pc;
        ex_rdata1_i     <= a;
        ex_rdata2_i     <= b;
        ex_imm16_i      <= i16[15:0];
        ex_imm26_i      <= i26[25:0];
        ex_base_src_i   <= f[0];
        ex_offs_src_i   <= f[1];
        ex_pred_taken_i <= f[2];
        stall_i         <= f[3];
        // pc plus 4 or the real target or a random one
        ex_pred_pc_i    <= f[4] ? pc + 32'd4 : (f[5] ? tgt : {r[29:0], 2'b00});
    endtask

    // beq to itself at TRAIN_PC with no taken prediction
    task automatic drive_loop(input logic taken);
        @(posedge clk_i);
        ex_valid_i      <= 1'b1;
        ex_jmp_i        <= 1'b0;
        ex_op_i         <= BR_EQ;
        ex_pc_i         <= TRAIN_PC;
        ex_base_src_i   <= 1'b0;
        ex_offs_src_i   <= 1'b0;
        ex_imm16_i      <= '0;
        ex_rdata1_i     <= '0;
        ex_rdata2_i     <= {31'b0, !taken};
        ex_pred_taken_i <= 1'b0;
        ex_pred_pc_i    <= TRAIN_PC + 32'd4;
        stall_i         <= 1'b0;
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // flush must stay low with nothing in execute
        repeat (IDLE_CYCLES) @(posedge clk_i);
        for (int i = 0; i < COND_CYCLES; i++) begin
            drive_random(1'b1, 1'b0, branch_op_e'(i % 7));
        end
        // jumps exercise both offsets and both bases
        for (int i = 0; i < TGT_CYCLES; i++) begin
            drive_random(1'b1, 1'b1, BR_NONE);
        end
        for (int i = 0; i < TRAIN_CYCLES; i++) begin
            drive_loop(1'b1);
        end
        for (int i = 0; i < TRAIN_CYCLES; i++) begin
            drive_loop(1'b0);
        end
        // sparse branches under random stall
        for (int i = 0; i < SEQ_CYCLES; i++) begin
            take_bits(7, pick);
            drive_random(pick[6:4] == 3'd0, pick[0], branch_op_e'(pick[3:1] % 3'd7));
        end
        @(posedge clk_i);
        ex_valid_i <= 1'b0;
        stall_i    <= 1'b0;
        repeat (4) @(posedge clk_i);
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/bp_pkg.sv
source/pht.sv
source/btb.sv
source/pc_gen.sv
source/branch_unit.sv
source/branch_predictor_top.sv
tb/tb_checker.sv
tb/tb_top.sv
